//--- Makefile
# Verilator build and run of the tx_frontend testbench

TOP := tb_tx_frontend

sim:
	verilator --binary --timing --assert -Wno-fatal -f tx_frontend.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- dv/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
   parameter int RESET_CYCLES = 8
) (
   output logic o_clk,
   output logic o_rst_n
);
   initial begin
      o_clk   = 1'b0;
      o_rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge o_clk);
      o_rst_n <= 1'b1;
   end

   always #2 o_clk = ~o_clk;  // 4 ns period

endmodule

//--- dv/tb_tx_frontend.sv
`timescale 1ns/1ps
`include "tx_frontend_params.svh"

module tb_tx_frontend;
   import tx_frontend_pkg::*;

   localparam set_addr_t BASE = 8'h20;
   localparam int ERR_BITS = `TX_SAMPLE_BITS - `TX_DAC_BITS;

   typedef logic signed [`TX_DAC_BITS-1:0] dac_t;

   logic        clk;
   logic        rst_n;
   logic        check_en = 1'b0;
   logic [31:0] rng = 32'h868d4345;
   set_bus_t    set_bus;
   iq_t         tx;
   dac_t        dac_a;
   dac_t        dac_b;
   mux_sel_t    route_a [3] = '{4'd0, 4'd1, 4'd7};
   mux_sel_t    route_b [3] = '{4'd1, 4'd7, 4'd0};

   // Reference model state
   tx_cfg_t m_cfg;
   iq_t     m_tx_d;
   iq_t     m_bal;
   iq_t     m_ofs;
   int      m_mag;
   int      m_phase;
   int      m_err_i;
   int      m_err_q;
   dac_t    m_rnd_i;
   dac_t    m_rnd_q;
   dac_t    m_dac_a;
   dac_t    m_dac_b;

   tb_clock_gen u_clock (.o_clk(clk), .o_rst_n(rst_n));

   tx_frontend #(.BASE(BASE), .WIDTH_OUT(`TX_DAC_BITS)) DUT (
      .clk     (clk),
      .i_rst_n (rst_n),
      .i_set   (set_bus),
      .i_tx    (tx),
      .o_dac_a (dac_a),
      .o_dac_b (dac_b)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   function automatic sample_t clip24(input longint v);
      if (v > 64'sd8388607)
         return 24'sh7fffff;
      if (v < -64'sd8388608)
         return 24'sh800000;
      return sample_t'(v);
   endfunction

   // Top 18 bits of I times the coefficient, over 2^16
   function automatic int balance_term(input sample_t i, input corr_t c);
      longint p;
      p = longint'(i >>> 6) * longint'(c);
      return int'(p >>> 16);
   endfunction

   function automatic dac_t sd_out(input longint sum);
      longint q;
      q = sum >>> ERR_BITS;
      if (q > 32767)
         return 16'sh7fff;
      if (q < -32768)
         return 16'sh8000;
      return dac_t'(q);
   endfunction

   function automatic int sd_err(input longint sum);
      longint q;
      q = sum >>> ERR_BITS;
      return (q > 32767 || q < -32768) ? 0 : int'(sum & ((1 << ERR_BITS) - 1));
   endfunction

   function automatic dac_t pick(input mux_sel_t sel, input dac_t di, input dac_t dq);
      if (sel == 4'd0)
         return di;
      if (sel == 4'd1)
         return dq;
      return '0;
   endfunction

   always @(posedge clk) begin : ref_model
      longint sum_i;
      longint sum_q;
      int     ofs;
      sum_i = longint'(m_ofs.i) + m_err_i;
      sum_q = longint'(m_ofs.q) + m_err_q;
      ofs = int'(set_bus.addr) - int'(BASE);
      if (!rst_n) begin
         m_cfg   <= '0;
         m_tx_d  <= '0;
         m_bal   <= '0;
         m_ofs   <= '0;
         m_mag   <= 0;
         m_phase <= 0;
         m_err_i <= 0;
         m_err_q <= 0;
         m_rnd_i <= '0;
         m_rnd_q <= '0;
         m_dac_a <= '0;
         m_dac_b <= '0;
      end else begin
         if (set_bus.stb) begin
            case (ofs)
               0: m_cfg.i_dco <= sample_t'(set_bus.data[23:0]);
               1: m_cfg.q_dco <= sample_t'(set_bus.data[23:0]);
               2: m_cfg.mag_corr <= corr_t'(set_bus.data[17:0]);
               3: m_cfg.phase_corr <= corr_t'(set_bus.data[17:0]);
               4: begin
                  m_cfg.mux_a <= set_bus.data[3:0];
                  m_cfg.mux_b <= set_bus.data[7:4];
               end
               default: ;
            endcase
         end
         m_mag   <= balance_term(tx.i, m_cfg.mag_corr);
         m_phase <= balance_term(tx.i, m_cfg.phase_corr);
         m_tx_d  <= tx;
         m_bal.i <= clip24(longint'(m_tx_d.i) + m_mag);
         m_bal.q <= clip24(longint'(m_tx_d.q) + m_phase);
         m_ofs.i <= clip24(longint'(m_bal.i) + longint'(m_cfg.i_dco));
         m_ofs.q <= clip24(longint'(m_bal.q) + longint'(m_cfg.q_dco));
         m_rnd_i <= sd_out(sum_i);
         m_rnd_q <= sd_out(sum_q);
         m_err_i <= sd_err(sum_i);
         m_err_q <= sd_err(sum_q);
         m_dac_a <= pick(m_cfg.mux_a, m_rnd_i, m_rnd_q);
         m_dac_b <= pick(m_cfg.mux_b, m_rnd_i, m_rnd_q);
      end
   end

   task automatic fail_run(input string why);
      $display("%s", why);
      $display(">>> FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic report_mismatch(input string name, input int got, input int exp);
      $display("mismatch at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
      fail_run("output differs from the reference model");
   endtask

   assert property (@(posedge clk) disable iff (!check_en) dac_a == m_dac_a)
      else report_mismatch("o_dac_a", $sampled(dac_a), $sampled(m_dac_a));

   assert property (@(posedge clk) disable iff (!check_en) dac_b == m_dac_b)
      else report_mismatch("o_dac_b", $sampled(dac_b), $sampled(m_dac_b));

   task automatic write_setting(input int ofs, input set_data_t data);
      @(posedge clk);
      set_bus <= '{stb: 1'b1, addr: set_addr_t'(int'(BASE) + ofs), data: data};
      @(posedge clk);
      set_bus.stb <= 1'b0;
   endtask

   task automatic send_samples(input int n, input logic clear_low);
      iq_t s;
      repeat (n) begin
         rng = xorshift32(rng);
         s.i = sample_t'(rng[23:0]);
         rng = xorshift32(rng);
         s.q = sample_t'(rng[23:0]);
         if (clear_low) begin
            s.i[7:0] = '0;
            s.q[7:0] = '0;
         end
         @(posedge clk);
         tx <= s;
      end
   endtask

   task automatic wait_reset_release();
      int n;
      n = 0;
      while (rst_n !== 1'b1) begin
         if (n == 20) begin
            fail_run("reset was never released");
         end else begin
            n++;
            @(posedge clk);
         end
      end
   endtask

   task automatic wait_levels(input dac_t lvl_a, input dac_t lvl_b);
      int n;
      n = 0;
      while (dac_a !== lvl_a || dac_b !== lvl_b) begin
         if (n == 40) begin
            fail_run("DAC outputs did not reach their clip levels");
         end else begin
            n++;
            @(negedge clk);
         end
      end
   endtask

   initial begin
      int      sum_dac;
      int      sum_model;
      sample_t level;
      set_bus = '0;
      tx = '0;
      @(posedge clk);
      check_en <= 1'b1;
      wait_reset_release();
      repeat (6) @(posedge clk);

      // Settings still at reset, so samples pass straight through
      send_samples(64, 1'b1);

      // Neighbouring addresses must be ignored
      write_setting(5, 32'h00ff_ffff);
      write_setting(-1, 32'h00ff_ffff);
      write_setting(-16, 32'h0000_0077);
      send_samples(16, 1'b0);
      for (int k = 0; k < 3; k++) begin
         write_setting(`TX_SR_MUX, {24'd0, route_b[k], route_a[k]});
         send_samples(24, 1'b0);
      end

      write_setting(`TX_SR_MUX, 32'h0000_0010);
      for (int k = 0; k < 6; k++) begin
         rng = xorshift32(rng);
         write_setting(`TX_SR_MAG, (k == 0) ? 32'h0003_0000 : rng);
         rng = xorshift32(rng);
         write_setting(`TX_SR_PHASE, (k == 0) ? 32'h0002_0001 : rng);
         send_samples(40, 1'b0);
      end

      // Full scale plus large offsets
      write_setting(`TX_SR_MAG, 32'd0);
      write_setting(`TX_SR_PHASE, 32'd0);
      write_setting(`TX_SR_I_DCO, 32'h007f_0000);
      write_setting(`TX_SR_Q_DCO, 32'h0081_0000);
      @(posedge clk);
      tx <= '{i: 24'sh7fffff, q: 24'sh800000};
      wait_levels(16'sh7fff, 16'sh8000);
      write_setting(`TX_SR_I_DCO, 32'h0081_0000);
      write_setting(`TX_SR_Q_DCO, 32'h007f_0000);
      @(posedge clk);
      tx <= '{i: 24'sh800000, q: 24'sh7fffff};
      wait_levels(16'sh8000, 16'sh7fff);
      send_samples(32, 1'b0);

      write_setting(`TX_SR_I_DCO, 32'd0);
      write_setting(`TX_SR_Q_DCO, 32'd0);
      rng = xorshift32(rng);
      level = sample_t'(rng[23:0]);
      level[22] = level[23];  // Keep clear of the clip range
      if (level[7:0] == 8'd0)
         level[7:0] = 8'h5b;
      @(posedge clk);
      tx <= '{i: level, q: -level};
      repeat (8) @(posedge clk);
      sum_dac = 0;
      sum_model = 0;
      repeat (256) begin
         @(negedge clk);
         sum_dac += dac_a;
         sum_model += m_dac_a;
      end
      assert (sum_dac == sum_model)
         else report_mismatch("o_dac_a sum", sum_dac, sum_model);
      assert (sum_dac - level <= 1 && level - sum_dac <= 1)
         else fail_run("rounded sum is more than one LSB away from the input level");

      send_samples(8, 1'b0);
      $display(">>> PASS");
      $finish;
   end

endmodule

//--- dv/tx_frontend_properties.sv
`timescale 1ns/1ps
`include "tx_frontend_params.svh"

module tx_frontend_properties #(
   parameter tx_frontend_pkg::set_addr_t BASE      = '0,
   parameter int                         WIDTH_OUT = `TX_DAC_BITS
) (
   input logic                        clk,
   input logic                        i_rst_n,
   input tx_frontend_pkg::set_bus_t   i_set,
   input tx_frontend_pkg::tx_cfg_t    i_cfg,
   input logic signed [WIDTH_OUT-1:0] i_dac_a,
   input logic signed [WIDTH_OUT-1:0] i_dac_b
);
   import tx_frontend_pkg::*;

   localparam int LAST_OFS = `TX_SR_MUX;

   logic own_write;

   // Strobe aimed at one of the five setting registers
   assign own_write = i_set.stb && (set_addr_t'(i_set.addr - BASE) <= LAST_OFS);

   assert property (@(posedge clk) $rose(i_rst_n) |=> (i_dac_a == '0 && i_dac_b == '0))
      else $error("DAC outputs not zero on the cycle after reset release");

   assert property (@(posedge clk) disable iff (!i_rst_n)
      (i_cfg.mux_a >= 4'd2) |=> (i_dac_a == '0))
      else $error("DAC A not zero under an unused mux code");

   assert property (@(posedge clk) disable iff (!i_rst_n)
      (i_cfg.mux_b >= 4'd2) |=> (i_dac_b == '0))
      else $error("DAC B not zero under an unused mux code");

   // Registers only move on their own addresses
   assert property (@(posedge clk) disable iff (!i_rst_n) !own_write |=> $stable(i_cfg))
      else $error("settings changed without a matching write");

endmodule

bind tx_frontend tx_frontend_properties #(
   .BASE      (BASE),
   .WIDTH_OUT (WIDTH_OUT)
) u_properties (
   .clk     (clk),
   .i_rst_n (i_rst_n),
   .i_set   (i_set),
   .i_cfg   (cfg),
   .i_dac_a (o_dac_a),
   .i_dac_b (o_dac_b)
);

//--- logic/iq_correct.sv
`timescale 1ns/1ps
`include "tx_frontend_params.svh"

module iq_correct (
   input  logic                     clk,
   input  logic                     i_rst_n,
   input  tx_frontend_pkg::iq_t     i_tx,
   input  tx_frontend_pkg::tx_cfg_t i_cfg,
   output tx_frontend_pkg::iq_t     o_ofs
);
   import tx_frontend_pkg::*;

   localparam int PROD_BITS  = 2 * `TX_CORR_BITS;
   localparam int CORR_SHIFT = 16;

   typedef logic signed [PROD_BITS-1:0] prod_t;

   // Signed add, clipped to the sample range
   function automatic sample_t sat_add(input sample_t a, input sample_t b);
      logic [`TX_SAMPLE_BITS:0] sum;
      sample_t res;
      sum = {a[`TX_SAMPLE_BITS-1], a} + {b[`TX_SAMPLE_BITS-1], b};
      if (sum[`TX_SAMPLE_BITS] != sum[`TX_SAMPLE_BITS-1]) begin
         if (sum[`TX_SAMPLE_BITS])
            res = {1'b1, {(`TX_SAMPLE_BITS-1){1'b0}}};
         else
            res = {1'b0, {(`TX_SAMPLE_BITS-1){1'b1}}};
      end else begin
         res = sum[`TX_SAMPLE_BITS-1:0];
      end
      return res;
   endfunction

   corr_t   i18;
   prod_t   mag_prod;
   prod_t   phase_prod;
   iq_t     tx_d;
   sample_t mag_fix;
   sample_t phase_fix;
   iq_t     bal;
   iq_t     ofs;

   assign i18 = corr_t'(i_tx.i[`TX_SAMPLE_BITS-1 -: `TX_CORR_BITS]);  // Top of I

   // Stage 1 multiply, sample delayed to match
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         mag_prod   <= '0;
         phase_prod <= '0;
         tx_d       <= '0;
      end else begin
         mag_prod   <= i18 * i_cfg.mag_corr;
         phase_prod <= i18 * i_cfg.phase_corr;
         tx_d       <= i_tx;
      end
   end

   assign mag_fix   = sample_t'(mag_prod >>> CORR_SHIFT);
   assign phase_fix = sample_t'(phase_prod >>> CORR_SHIFT);

   // Stage 2 balance, both terms scaled from I
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         bal <= '0;
      end else begin
         bal.i <= sat_add(tx_d.i, mag_fix);
         bal.q <= sat_add(tx_d.q, phase_fix);
      end
   end

   // Stage 3 DC offset
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         ofs <= '0;
      end else begin
         ofs.i <= sat_add(bal.i, i_cfg.i_dco);
         ofs.q <= sat_add(bal.q, i_cfg.q_dco);
      end
   end

   assign o_ofs = ofs;

endmodule

//--- logic/round_sd.sv
`timescale 1ns/1ps
`include "tx_frontend_params.svh"

module round_sd #(
   parameter int WIDTH_OUT = `TX_DAC_BITS
) (
   input  logic                        clk,
   input  logic                        i_rst_n,
   input  tx_frontend_pkg::sample_t    i_in,
   output logic signed [WIDTH_OUT-1:0] o_out
);
   import tx_frontend_pkg::*;

   localparam int IN_BITS  = $bits(sample_t);
   localparam int ERR_BITS = IN_BITS - WIDTH_OUT;

   logic [ERR_BITS-1:0]         err;  // Unsigned residue
   logic [IN_BITS:0]            sum;
   logic                        ovf;
   logic signed [WIDTH_OUT-1:0] out_sat;

   assign sum = {i_in[IN_BITS-1], i_in} + {{(WIDTH_OUT+1){1'b0}}, err};
   assign ovf = sum[IN_BITS] != sum[IN_BITS-1];

   always_comb begin
      if (!ovf)
         out_sat = sum[IN_BITS-1:ERR_BITS];
      else if (sum[IN_BITS])
         out_sat = {1'b1, {(WIDTH_OUT-1){1'b0}}};
      else
         out_sat = {1'b0, {(WIDTH_OUT-1){1'b1}}};
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_out <= '0;
         err   <= '0;
      end else begin
         o_out <= out_sat;
         err   <= ovf ? '0 : sum[ERR_BITS-1:0];  // Drop residue when clipped
      end
   end

endmodule

//--- logic/tx_frontend.sv
`timescale 1ns/1ps
`include "tx_frontend_params.svh"

module tx_frontend #(
   parameter tx_frontend_pkg::set_addr_t BASE      = '0,
   parameter int                         WIDTH_OUT = `TX_DAC_BITS
) (
   input  logic                        clk,
   input  logic                        i_rst_n,
   input  tx_frontend_pkg::set_bus_t   i_set,
   input  tx_frontend_pkg::iq_t        i_tx,
   output logic signed [WIDTH_OUT-1:0] o_dac_a,
   output logic signed [WIDTH_OUT-1:0] o_dac_b
);
   import tx_frontend_pkg::*;

   typedef logic signed [WIDTH_OUT-1:0] dac_t;

   tx_cfg_t cfg;
   iq_t     ofs;
   dac_t    rnd_i;
   dac_t    rnd_q;

   // I, Q or zero
   function automatic dac_t route(input mux_sel_t sel, input dac_t di, input dac_t dq);
      dac_t res;
      case (sel)
         `TX_MUX_I: res = di;
         `TX_MUX_Q: res = dq;
         default:   res = '0;
      endcase
      return res;
   endfunction

   tx_settings #(.BASE(BASE)) u_settings (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_set   (i_set),
      .o_cfg   (cfg)
   );

   iq_correct u_correct (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_tx    (i_tx),
      .i_cfg   (cfg),
      .o_ofs   (ofs)
   );

   round_sd #(.WIDTH_OUT(WIDTH_OUT)) u_round_i (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_in    (ofs.i),
      .o_out   (rnd_i)
   );

   round_sd #(.WIDTH_OUT(WIDTH_OUT)) u_round_q (
      .clk     (clk),
      .i_rst_n (i_rst_n),
      .i_in    (ofs.q),
      .o_out   (rnd_q)
   );

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_dac_a <= '0;
         o_dac_b <= '0;
      end else begin
         o_dac_a <= route(cfg.mux_a, rnd_i, rnd_q);
         o_dac_b <= route(cfg.mux_b, rnd_i, rnd_q);
      end
   end

endmodule

//--- logic/tx_frontend_params.svh
`ifndef TX_FRONTEND_PARAMS_SVH
`define TX_FRONTEND_PARAMS_SVH

// Settings bus
`define TX_SET_ADDR_BITS 8
`define TX_SET_DATA_BITS 32

// Datapath widths
`define TX_SAMPLE_BITS 24
`define TX_CORR_BITS 18
`define TX_DAC_BITS 16

// Offsets from BASE
`define TX_SR_I_DCO 0
`define TX_SR_Q_DCO 1
`define TX_SR_MAG 2
`define TX_SR_PHASE 3
`define TX_SR_MUX 4

// DAC routing, other codes give zero
`define TX_MUX_SEL_BITS 4
`define TX_MUX_I 4'd0
`define TX_MUX_Q 4'd1

`endif

//--- logic/tx_frontend_pkg.sv
`include "tx_frontend_params.svh"

package tx_frontend_pkg;

   typedef logic signed [`TX_SAMPLE_BITS-1:0] sample_t;
   typedef logic signed [`TX_CORR_BITS-1:0]   corr_t;
   typedef logic [`TX_SET_ADDR_BITS-1:0]      set_addr_t;
   typedef logic [`TX_SET_DATA_BITS-1:0]      set_data_t;
   typedef logic [`TX_MUX_SEL_BITS-1:0]       mux_sel_t;

   typedef struct packed {
      sample_t i;
      sample_t q;
   } iq_t;

   typedef struct packed {
      logic      stb;  // One cycle per write
      set_addr_t addr;
      set_data_t data;
   } set_bus_t;

   typedef struct packed {
      sample_t  i_dco;
      sample_t  q_dco;
      corr_t    mag_corr;
      corr_t    phase_corr;
      mux_sel_t mux_a;
      mux_sel_t mux_b;
   } tx_cfg_t;

endpackage

//--- logic/tx_settings.sv
`timescale 1ns/1ps
`include "tx_frontend_params.svh"

module tx_settings #(
   parameter tx_frontend_pkg::set_addr_t BASE = '0
) (
   input  logic                      clk,
   input  logic                      i_rst_n,
   input  tx_frontend_pkg::set_bus_t i_set,
   output tx_frontend_pkg::tx_cfg_t  o_cfg
);
   import tx_frontend_pkg::*;

   localparam set_addr_t ADDR_I_DCO = set_addr_t'(BASE + `TX_SR_I_DCO);
   localparam set_addr_t ADDR_Q_DCO = set_addr_t'(BASE + `TX_SR_Q_DCO);
   localparam set_addr_t ADDR_MAG   = set_addr_t'(BASE + `TX_SR_MAG);
   localparam set_addr_t ADDR_PHASE = set_addr_t'(BASE + `TX_SR_PHASE);
   localparam set_addr_t ADDR_MUX   = set_addr_t'(BASE + `TX_SR_MUX);

   tx_cfg_t cfg_q;

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         cfg_q <= '0;
      end else if (i_set.stb) begin
         case (i_set.addr)
            ADDR_I_DCO: cfg_q.i_dco <= sample_t'(i_set.data[`TX_SAMPLE_BITS-1:0]);
            ADDR_Q_DCO: cfg_q.q_dco <= sample_t'(i_set.data[`TX_SAMPLE_BITS-1:0]);
            ADDR_MAG:   cfg_q.mag_corr <= corr_t'(i_set.data[`TX_CORR_BITS-1:0]);
            ADDR_PHASE: cfg_q.phase_corr <= corr_t'(i_set.data[`TX_CORR_BITS-1:0]);
            ADDR_MUX: begin
               // Low nibble DAC A, next nibble DAC B
               cfg_q.mux_a <= i_set.data[`TX_MUX_SEL_BITS-1:0];
               cfg_q.mux_b <= i_set.data[2*`TX_MUX_SEL_BITS-1:`TX_MUX_SEL_BITS];
            end
            default: ;  // Not ours
         endcase
      end
   end

   assign o_cfg = cfg_q;

endmodule

//--- tx_frontend.f
+incdir+logic
logic/tx_frontend_pkg.sv
logic/tx_settings.sv
logic/iq_correct.sv
logic/round_sd.sv
logic/tx_frontend.sv
dv/tb_clock_gen.sv
dv/tx_frontend_properties.sv
dv/tb_tx_frontend.sv
